// ==== hdl/serdes_pkg.sv ====
package serdes_pkg;

  ////////////////////////////////////////
  // Stream and link widths
  ////////////////////////////////////////
  localparam int DATA_W     = 32;
  localparam int STRB_W     = DATA_W / 8;
  localparam int CLK_RATIO  = 4;                      // ioclk cycles per core beat
  localparam int PHASE_W    = $clog2(CLK_RATIO);
  localparam int DATA_LANES = DATA_W / CLK_RATIO;
  localparam int SERIAL_W   = DATA_LANES + 4;         // data + strb, keep, id/user, fc

  // Lane positions above the data lanes
  localparam int STRB_LANE = DATA_LANES;
  localparam int KEEP_LANE = DATA_LANES + 1;
  localparam int IDU_LANE  = DATA_LANES + 2;
  localparam int FC_LANE   = DATA_LANES + 3;

  localparam logic [PHASE_W-1:0] LAST_PHASE = PHASE_W'(CLK_RATIO - 1);

  ////////////////////////////////////////
  // Config space
  ////////////////////////////////////////
  localparam int ADDR_W = 15;
  localparam logic [9:0] CTRL_OFFSET = 10'd0;         // word offset, addr[11:2]
  localparam int RXEN_BIT = 0;
  localparam int TXEN_BIT = 1;

  typedef enum logic {
    LINK_OFF = 1'b0,
    LINK_ON  = 1'b1
  } link_state_e;

  typedef struct packed {
    logic [DATA_W-1:0] tdata;
    logic [STRB_W-1:0] tstrb;
    logic [STRB_W-1:0] tkeep;
    logic [1:0]        tid;
    logic [1:0]        tuser;
    logic              tlast;
    logic              tvalid;
    logic              tready;
  } axis_beat_t;

endpackage

// ==== hdl/link_ctrl_if.sv ====
`timescale 1ns/1ps

interface link_ctrl_if;

  logic [serdes_pkg::PHASE_W-1:0] phase_cnt;   // Core beat phase
  serdes_pkg::link_state_e        txen;
  serdes_pkg::link_state_e        rxen;
  logic                           rx_received; // Partner heard at least once

  modport ctrl (
    output phase_cnt, txen, rxen,
    input  rx_received
  );

  modport tx (
    input phase_cnt, txen
  );

  modport rx (
    input  phase_cnt, txen, rxen,
    output rx_received
  );

endinterface

// ==== hdl/serdes_link_ctrl.sv ====
`timescale 1ns/1ps

module serdes_link_ctrl (
  input  logic                            ioclk,
  input  logic                            axis_rst_n,
  input  logic                            axi_awvalid,
  input  logic [serdes_pkg::ADDR_W-1:0]   axi_awaddr,
  output logic                            axi_awready,
  input  logic                            axi_wvalid,
  input  logic [serdes_pkg::DATA_W-1:0]   axi_wdata,
  input  logic [serdes_pkg::STRB_W-1:0]   axi_wstrb,
  output logic                            axi_wready,
  output logic                            axi_arready,
  output logic                            axi_rvalid,
  output logic [serdes_pkg::DATA_W-1:0]   axi_rdata,
  input  logic                            cc_is_enable,
  link_ctrl_if.ctrl                       link
);

  logic                           wr_hit;
  logic                           ctrl_sel;
  logic                           rxen_ctl;
  logic                           txen_ctl;
  logic [serdes_pkg::PHASE_W-1:0] phase_cnt;
  serdes_pkg::link_state_e        rxen_q;
  serdes_pkg::link_state_e        txen_q;

  ////////////////////////////////////////
  // AXI-lite config port
  ////////////////////////////////////////
  assign wr_hit   = axi_awvalid & axi_wvalid & cc_is_enable;
  assign ctrl_sel = (axi_awaddr[11:2] == serdes_pkg::CTRL_OFFSET) & axi_wstrb[0];

  assign axi_awready = wr_hit;   // Single-cycle accept
  assign axi_wready  = wr_hit;
  assign axi_arready = 1'b1;
  assign axi_rvalid  = 1'b1;

  always_comb begin
    axi_rdata = '0;
    axi_rdata[serdes_pkg::RXEN_BIT] = rxen_ctl;
    axi_rdata[serdes_pkg::TXEN_BIT] = txen_ctl;
  end

  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      rxen_ctl <= 1'b0;
      txen_ctl <= 1'b0;
    end else if (wr_hit && ctrl_sel) begin
      rxen_ctl <= axi_wdata[serdes_pkg::RXEN_BIT];
      txen_ctl <= axi_wdata[serdes_pkg::TXEN_BIT];
    end
  end

  ////////////////////////////////////////
  // Phase counter and sticky enables
  ////////////////////////////////////////
  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      phase_cnt <= '0;
    end else begin
      phase_cnt <= phase_cnt + 1'b1;   // Wraps after last phase
    end
  end

  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      rxen_q <= serdes_pkg::LINK_OFF;
      txen_q <= serdes_pkg::LINK_OFF;
    end else begin
      if (rxen_ctl)
        rxen_q <= serdes_pkg::LINK_ON;
      // Partner traffic also opens tx, so our ready reaches it
      if (phase_cnt == serdes_pkg::LAST_PHASE && (txen_ctl || link.rx_received))
        txen_q <= serdes_pkg::LINK_ON;
    end
  end

  assign link.phase_cnt = phase_cnt;
  assign link.rxen      = rxen_q;
  assign link.txen      = txen_q;

  a_heard_needs_rxen: assert property (
    @(posedge ioclk) disable iff (!axis_rst_n)
    link.rx_received |-> rxen_q == serdes_pkg::LINK_ON
  );

endmodule

// ==== hdl/serdes_tx.sv ====
`timescale 1ns/1ps

module serdes_tx (
  input  logic                              ioclk,
  input  logic                              axis_rst_n,
  input  serdes_pkg::axis_beat_t            beat_in,
  input  logic                              is_as_tready,
  link_ctrl_if.tx                           link,
  output logic [serdes_pkg::SERIAL_W-1:0]   serial_txd
);

  logic                             capture;
  serdes_pkg::axis_beat_t           beat_q;
  logic [serdes_pkg::CLK_RATIO-1:0] lane_nib [serdes_pkg::SERIAL_W];

  // One capture per core beat, at the last phase
  assign capture = (link.txen == serdes_pkg::LINK_ON) &&
                   (link.phase_cnt == serdes_pkg::LAST_PHASE);

  ////////////////////////////////////////
  // Beat capture
  ////////////////////////////////////////
  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      beat_q <= '0;   // Stays zero until txen
    end else if (capture) begin
      beat_q        <= beat_in;
      beat_q.tvalid <= beat_in.tvalid & is_as_tready; // Only send what partner can take
    end
  end

  ////////////////////////////////////////
  // Nibble per lane
  ////////////////////////////////////////
  always_comb begin
    for (int k = 0; k < serdes_pkg::DATA_LANES; k++) begin
      lane_nib[k] = beat_q.tdata[serdes_pkg::CLK_RATIO*k +: serdes_pkg::CLK_RATIO];
    end
    lane_nib[serdes_pkg::STRB_LANE] = beat_q.tstrb;
    lane_nib[serdes_pkg::KEEP_LANE] = beat_q.tkeep;
    lane_nib[serdes_pkg::IDU_LANE]  = {beat_q.tid, beat_q.tuser};
    lane_nib[serdes_pkg::FC_LANE]   = {1'b0, beat_q.tlast, beat_q.tvalid, beat_q.tready};
  end

  // Bit p of each nibble goes out in phase p
  always_comb begin
    for (int l = 0; l < serdes_pkg::SERIAL_W; l++) begin
      serial_txd[l] = lane_nib[l][link.phase_cnt];
    end
  end

  a_txd_quiet_off: assert property (
    @(posedge ioclk) disable iff (!axis_rst_n)
    link.txen == serdes_pkg::LINK_OFF |-> serial_txd == '0
  );

endmodule

// ==== hdl/serdes_rx.sv ====
`timescale 1ns/1ps

module serdes_rx (
  input  logic                              ioclk,
  input  logic                              axis_rst_n,
  input  logic [serdes_pkg::SERIAL_W-1:0]   serial_rxd,
  link_ctrl_if.rx                           link,
  output serdes_pkg::axis_beat_t            beat_out,
  output logic                              is_as_tready
);

  logic                             last_phase;
  logic                             publish;
  logic                             fc_hit;
  logic                             rcv_next;
  logic                             rx_received;
  logic [serdes_pkg::CLK_RATIO-2:0] lane_sh  [serdes_pkg::SERIAL_W];
  logic [serdes_pkg::CLK_RATIO-1:0] lane_nib [serdes_pkg::SERIAL_W];
  serdes_pkg::axis_beat_t           rx_word;

  assign last_phase = link.phase_cnt == serdes_pkg::LAST_PHASE;
  assign publish    = last_phase && (link.rxen == serdes_pkg::LINK_ON);

  ////////////////////////////////////////
  // Lane shift-in
  ////////////////////////////////////////
  always_ff @(posedge ioclk) begin
    if (link.rxen == serdes_pkg::LINK_ON && !last_phase) begin
      for (int l = 0; l < serdes_pkg::SERIAL_W; l++) begin
        lane_sh[l][link.phase_cnt] <= serial_rxd[l];
      end
    end
  end

  // Last bit taken straight from the line
  always_comb begin
    for (int l = 0; l < serdes_pkg::SERIAL_W; l++) begin
      lane_nib[l] = {serial_rxd[l], lane_sh[l]};
    end
  end

  always_comb begin
    for (int k = 0; k < serdes_pkg::DATA_LANES; k++) begin
      rx_word.tdata[serdes_pkg::CLK_RATIO*k +: serdes_pkg::CLK_RATIO] = lane_nib[k];
    end
    rx_word.tstrb = lane_nib[serdes_pkg::STRB_LANE];
    rx_word.tkeep = lane_nib[serdes_pkg::KEEP_LANE];
    {rx_word.tid, rx_word.tuser} = lane_nib[serdes_pkg::IDU_LANE];
    {rx_word.tlast, rx_word.tvalid, rx_word.tready} = lane_nib[serdes_pkg::FC_LANE][2:0];
  end

  assign fc_hit   = publish && (lane_nib[serdes_pkg::FC_LANE] != '0);
  assign rcv_next = rx_received | fc_hit;

  ////////////////////////////////////////
  // Publish, partner detect, ready
  ////////////////////////////////////////
  always_ff @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      beat_out     <= '0;
      rx_received  <= 1'b0;
      is_as_tready <= 1'b0;
    end else begin
      if (publish)
        beat_out <= rx_word;
      rx_received <= rcv_next;   // Sticky
      if (last_phase && link.txen == serdes_pkg::LINK_ON)
        is_as_tready <= rcv_next ? rx_word.tready : 1'b1; // High until partner heard
    end
  end

  assign link.rx_received = rx_received;

  a_ready_low_no_tx: assert property (
    @(posedge ioclk) disable iff (!axis_rst_n)
    link.txen == serdes_pkg::LINK_OFF |-> !is_as_tready
  );

endmodule

// ==== hdl/io_serdes.sv ====
`timescale 1ns/1ps

module io_serdes (
  input  logic                              ioclk,
  input  logic                              axis_rst_n,
  // AXI-lite config
  input  logic                              axi_awvalid,
  input  logic [serdes_pkg::ADDR_W-1:0]     axi_awaddr,
  output logic                              axi_awready,
  input  logic                              axi_wvalid,
  input  logic [serdes_pkg::DATA_W-1:0]     axi_wdata,
  input  logic [serdes_pkg::STRB_W-1:0]     axi_wstrb,
  output logic                              axi_wready,
  input  logic                              axi_arvalid,  // Reads return ctrl word
  input  logic [serdes_pkg::ADDR_W-1:0]     axi_araddr,
  output logic                              axi_arready,
  output logic                              axi_rvalid,
  output logic [serdes_pkg::DATA_W-1:0]     axi_rdata,
  input  logic                              axi_rready,
  input  logic                              cc_is_enable,
  // Stream in
  input  logic [serdes_pkg::DATA_W-1:0]     as_is_tdata,
  input  logic [serdes_pkg::STRB_W-1:0]     as_is_tstrb,
  input  logic [serdes_pkg::STRB_W-1:0]     as_is_tkeep,
  input  logic                              as_is_tlast,
  input  logic [1:0]                        as_is_tid,
  input  logic                              as_is_tvalid,
  input  logic [1:0]                        as_is_tuser,
  input  logic                              as_is_tready,
  // Serial lanes
  output logic [serdes_pkg::SERIAL_W-1:0]   serial_txd,
  input  logic [serdes_pkg::SERIAL_W-1:0]   serial_rxd,
  // Stream out
  output logic [serdes_pkg::DATA_W-1:0]     is_as_tdata,
  output logic [serdes_pkg::STRB_W-1:0]     is_as_tstrb,
  output logic [serdes_pkg::STRB_W-1:0]     is_as_tkeep,
  output logic                              is_as_tlast,
  output logic [1:0]                        is_as_tid,
  output logic                              is_as_tvalid,
  output logic [1:0]                        is_as_tuser,
  output logic                              is_as_tready
);

  serdes_pkg::axis_beat_t tx_beat;
  serdes_pkg::axis_beat_t rx_beat;

  link_ctrl_if link ();

  assign tx_beat = {as_is_tdata, as_is_tstrb, as_is_tkeep, as_is_tid, as_is_tuser,
                    as_is_tlast, as_is_tvalid, as_is_tready};

  assign is_as_tdata  = rx_beat.tdata;
  assign is_as_tstrb  = rx_beat.tstrb;
  assign is_as_tkeep  = rx_beat.tkeep;
  assign is_as_tid    = rx_beat.tid;
  assign is_as_tuser  = rx_beat.tuser;
  assign is_as_tlast  = rx_beat.tlast;
  assign is_as_tvalid = rx_beat.tvalid;   // Partner tready stays inside rx

  serdes_link_ctrl i_link_ctrl (
    .ioclk, .axis_rst_n,
    .axi_awvalid, .axi_awaddr, .axi_awready,
    .axi_wvalid, .axi_wdata, .axi_wstrb, .axi_wready,
    .axi_arready, .axi_rvalid, .axi_rdata,
    .cc_is_enable,
    .link (link.ctrl)
  );

  serdes_tx i_tx (
    .ioclk, .axis_rst_n,
    .beat_in      (tx_beat),
    .is_as_tready (is_as_tready),
    .link         (link.tx),
    .serial_txd   (serial_txd)
  );

  serdes_rx i_rx (
    .ioclk, .axis_rst_n,
    .serial_rxd   (serial_rxd),
    .link         (link.rx),
    .beat_out     (rx_beat),
    .is_as_tready (is_as_tready)
  );

endmodule

// ==== tb/tb_io_serdes.sv ====
`timescale 1ns/1ps

module tb_io_serdes;

  localparam int NUM_BEATS   = 12;
  localparam int NUM_STEPS   = NUM_BEATS + 2;      // Two idle beats flush the link
  localparam int TIMEOUT_CYC = NUM_BEATS * 4 + 100;
  localparam int CLEAR_STEP  = 6;                  // Ctrl word cleared mid-stream

  // Flow bits per table entry, entry 0 at bit 0
  localparam logic [NUM_BEATS-1:0] VALID_PAT = 12'b1110_1111_0110;
  localparam logic [NUM_BEATS-1:0] READY_PAT = 12'b1011_0011_1111;
  localparam logic [NUM_BEATS-1:0] LAST_PAT  = 12'b1000_1000_1000;

  logic                            ioclk;
  logic                            axis_rst_n;
  logic                            axi_awvalid, axi_wvalid, axi_arvalid, axi_rready;
  logic                            axi_awready, axi_wready, axi_arready, axi_rvalid;
  logic                            cc_is_enable;
  logic [serdes_pkg::ADDR_W-1:0]   axi_awaddr, axi_araddr;
  logic [serdes_pkg::DATA_W-1:0]   axi_wdata, axi_rdata;
  logic [serdes_pkg::STRB_W-1:0]   axi_wstrb;
  logic [serdes_pkg::DATA_W-1:0]   as_is_tdata, is_as_tdata;
  logic [serdes_pkg::STRB_W-1:0]   as_is_tstrb, as_is_tkeep, is_as_tstrb, is_as_tkeep;
  logic [1:0]                      as_is_tid, as_is_tuser, is_as_tid, is_as_tuser;
  logic                            as_is_tlast, as_is_tvalid, as_is_tready;
  logic                            is_as_tlast, is_as_tvalid, is_as_tready;
  logic [serdes_pkg::SERIAL_W-1:0] serial_txd, serial_rxd;

  logic [serdes_pkg::PHASE_W-1:0]  phase;
  serdes_pkg::axis_beat_t          out_beat;
  serdes_pkg::axis_beat_t          stim_tbl [NUM_STEPS];
  serdes_pkg::axis_beat_t          exp_tbl  [NUM_STEPS];
  logic                            rdy_tbl  [NUM_STEPS];
  int                              cycle_cnt;

  io_serdes i_io_serdes (.*);

  assign serial_rxd = serial_txd;   // Loopback
  assign out_beat   = {is_as_tdata, is_as_tstrb, is_as_tkeep, is_as_tid, is_as_tuser,
                       is_as_tlast, is_as_tvalid, 1'b0};   // No tready on the is_as side

  initial ioclk = 1'b0;
  always #2 ioclk = ~ioclk;

  // Core beat phase, counted from reset release
  always @(posedge ioclk or negedge axis_rst_n) begin
    if (!axis_rst_n)
      phase <= '0;
    else
      phase <= phase + serdes_pkg::PHASE_W'(1);
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: t=%0t %s expected %b got %b", $time, name, exp, got);
      $display("TEST FAIL");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_word(input string name, input logic [serdes_pkg::DATA_W-1:0] got,
                            input logic [serdes_pkg::DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("Error: t=%0t %s expected %h got %h", $time, name, exp, got);
      $display("TEST FAIL");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_lanes(input string name, input logic [serdes_pkg::SERIAL_W-1:0] got,
                             input logic [serdes_pkg::SERIAL_W-1:0] exp);
    if (got !== exp) begin
      $display("Error: t=%0t %s expected %h got %h", $time, name, exp, got);
      $display("TEST FAIL");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_beat(input string name, input serdes_pkg::axis_beat_t got,
                            input serdes_pkg::axis_beat_t exp);
    if (got !== exp) begin
      $display("Error: t=%0t %s expected %h got %h", $time, name, exp, got);
      $display("TEST FAIL");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic drive_beat(input serdes_pkg::axis_beat_t b);
    as_is_tdata  = b.tdata;
    as_is_tstrb  = b.tstrb;
    as_is_tkeep  = b.tkeep;
    as_is_tid    = b.tid;
    as_is_tuser  = b.tuser;
    as_is_tlast  = b.tlast;
    as_is_tvalid = b.tvalid;
    as_is_tready = b.tready;
  endtask

  // Falling edge just after a capture edge
  task automatic wait_beat_start();
    @(negedge ioclk);
    while (phase != '0)
      @(negedge ioclk);
  endtask

  // Write lands on a phase 2 edge so both enables rise at the next phase 3 edge
  task automatic write_ctrl(input logic [serdes_pkg::ADDR_W-1:0] addr,
                            input logic [serdes_pkg::DATA_W-1:0] data,
                            input logic [serdes_pkg::STRB_W-1:0] strb,
                            input logic en, input logic [serdes_pkg::DATA_W-1:0] exp_rdata);
    @(negedge ioclk);
    while (phase != 2'd2)
      @(negedge ioclk);
    axi_awvalid  = 1'b1;
    axi_awaddr   = addr;
    axi_wvalid   = 1'b1;
    axi_wdata    = data;
    axi_wstrb    = strb;
    cc_is_enable = en;
    #1;
    check_bit("axi_awready", axi_awready, en);
    check_bit("axi_wready", axi_wready, en);
    @(negedge ioclk);
    axi_awvalid  = 1'b0;
    axi_wvalid   = 1'b0;
    cc_is_enable = 1'b0;
    check_word("axi_rdata", axi_rdata, exp_rdata);
  endtask

  // Expected is_as beat and ready at the start of each table step
  task automatic build_expected();
    serdes_pkg::axis_beat_t pending;
    serdes_pkg::axis_beat_t shown;
    serdes_pkg::axis_beat_t cap;
    logic                   ready;
    logic                   heard;
    pending = '0;
    shown   = '0;
    ready   = 1'b0;
    heard   = 1'b0;
    for (int j = 0; j < NUM_STEPS; j++) begin
      exp_tbl[j] = shown;
      rdy_tbl[j] = ready;
      cap        = stim_tbl[j];
      cap.tvalid = stim_tbl[j].tvalid & ready;   // Ready from before the edge
      // Previous capture is published at the same edge
      heard        = heard | pending.tlast | pending.tvalid | pending.tready;
      ready        = heard ? pending.tready : 1'b1;
      shown        = pending;
      shown.tready = 1'b0;
      pending      = cap;
    end
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYC) begin
      @(posedge ioclk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the stream did not finish", cycle_cnt);
    $display("TEST FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    logic [31:0] rnd;
    axis_rst_n   = 1'b0;
    axi_awvalid  = 1'b0;
    axi_awaddr   = '0;
    axi_wvalid   = 1'b0;
    axi_wdata    = '0;
    axi_wstrb    = '0;
    axi_arvalid  = 1'b0;
    axi_araddr   = '0;
    axi_rready   = 1'b1;
    cc_is_enable = 1'b0;
    drive_beat('0);

    ////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////
    rnd = 32'd57795;
    for (int i = 0; i < NUM_STEPS; i++) begin
      stim_tbl[i] = '0;
      if (i < NUM_BEATS) begin
        rnd = xorshift32(rnd);
        stim_tbl[i].tdata  = rnd;
        rnd = xorshift32(rnd);
        stim_tbl[i].tstrb  = rnd[3:0];
        stim_tbl[i].tkeep  = rnd[7:4];
        stim_tbl[i].tid    = rnd[9:8];
        stim_tbl[i].tuser  = rnd[11:10];
        stim_tbl[i].tlast  = LAST_PAT[i];
        stim_tbl[i].tvalid = VALID_PAT[i];
        stim_tbl[i].tready = READY_PAT[i];
      end
    end
    build_expected();

    repeat (3) @(negedge ioclk);
    axis_rst_n = 1'b1;
    @(negedge ioclk);
    check_word("axi_rdata", axi_rdata, '0);
    check_lanes("serial_txd", serial_txd, '0);
    check_bit("is_as_tvalid", is_as_tvalid, 1'b0);
    check_bit("is_as_tready", is_as_tready, 1'b0);
    check_bit("axi_arready", axi_arready, 1'b1);
    check_bit("axi_rvalid", axi_rvalid, 1'b1);

    ////////////////////////////////////////
    // Config writes
    ////////////////////////////////////////
    write_ctrl(15'h000, 32'h3, 4'hf, 1'b0, 32'h0);   // cc_is_enable low
    write_ctrl(15'h000, 32'h3, 4'he, 1'b1, 32'h0);   // wstrb[0] clear
    write_ctrl(15'h004, 32'h3, 4'hf, 1'b1, 32'h0);   // word offset 1
    check_lanes("serial_txd", serial_txd, '0);
    write_ctrl(15'h000, 32'h3, 4'h1, 1'b1, 32'h3);

    ////////////////////////////////////////
    // Looped stream
    ////////////////////////////////////////
    for (int j = 0; j < NUM_STEPS; j++) begin
      wait_beat_start();
      check_beat("is_as beat", out_beat, exp_tbl[j]);
      check_bit("is_as_tready", is_as_tready, rdy_tbl[j]);
      drive_beat(stim_tbl[j]);
      if (j == CLEAR_STEP)
        write_ctrl(15'h000, 32'h0, 4'h1, 1'b1, 32'h0);   // Enables stay sticky
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

// ==== compile.f ====
hdl/serdes_pkg.sv
hdl/link_ctrl_if.sv
hdl/serdes_link_ctrl.sv
hdl/serdes_tx.sv
hdl/serdes_rx.sv
hdl/io_serdes.sv
tb/tb_io_serdes.sv

// ==== run.sh ====
#!/bin/sh
# Build the io_serdes testbench with Verilator, run it, then scan the log
verilator --binary --assert --timescale 1ns/1ps --top-module tb_io_serdes \
  -f compile.f -Mdir obj_dir || exit 1
./obj_dir/Vtb_io_serdes > sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log || exit 1
exit 0
